//--- logic/udp_mux_pkg.sv
// width constants, udp header and payload beat structs, frame state enum
`default_nettype none

package udp_mux_pkg;

    // field widths of the udp header channel
    localparam int mac_width = 48;
    localparam int ip_width  = 32;
    localparam int len_width = 16;

    // payload is one byte per beat
    localparam int data_width = 8;

    // one header, 176 bits, dest_mac in the top bits
    typedef struct packed {
        logic [mac_width-1:0] dest_mac;
        logic [mac_width-1:0] src_mac;
        logic [len_width-1:0] length;
        logic [ip_width-1:0]  source_ip;
        logic [ip_width-1:0]  dest_ip;
    } udp_hdr_t;

    // one payload beat, 10 bits
    typedef struct packed {
        logic [data_width-1:0] data;
        // marks the final byte of the frame
        logic                  last;
        logic                  user;
    } udp_beat_t;

    // selector state
    // idle waits for a grant, busy passes payload until last
    typedef enum logic {
        frame_idle = 1'b0,
        frame_busy = 1'b1
    } frame_state_t;

endpackage

`default_nettype wire

//--- logic/rr_arbiter.sv
// round-robin arbiter with rotating priority mask and a registered grant held until acknowledge
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter #(
    parameter int port_count = 4
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire [port_count-1:0]         request,
    input  wire [port_count-1:0]         acknowledge,
    output logic                         grant_valid,
    output logic [$clog2(port_count)-1:0] grant_index
);

    localparam int index_width = $clog2(port_count);

    logic [port_count-1:0]  mask;
    logic [port_count-1:0]  mask_next;
    logic [port_count-1:0]  masked_request;
    logic                   grant_valid_next;
    logic [index_width-1:0] grant_index_next;

    // lowest set bit wins
    function automatic logic [index_width-1:0] lowest_set(input logic [port_count-1:0] vec);
        logic [index_width-1:0] idx;
        idx = '0;
        for (int i = port_count - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = index_width'(i);
            end
        end
        return idx;
    endfunction

    assign masked_request = request & mask;

    always_comb begin
        grant_valid_next = grant_valid;
        grant_index_next = grant_index;
        mask_next        = mask;

        // rearbitrate when empty or on the release cycle
        if (!grant_valid || acknowledge[grant_index]) begin
            grant_valid_next = |request;
            if (|masked_request) begin
                grant_index_next = lowest_set(masked_request);
            end else if (|request) begin
                grant_index_next = lowest_set(request);
            end

            // ports above the new winner go first next time
            if (|request) begin
                for (int k = 0; k < port_count; k++) begin
                    mask_next[k] = (k > int'(grant_index_next));
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            grant_index <= '0;
            // all ones so port 0 wins first
            mask        <= '1;
        end else begin
            grant_valid <= grant_valid_next;
            grant_index <= grant_index_next;
            mask        <= mask_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/udp_frame_select.sv
// frame tracking, header capture, payload selection and per-port ready steering
`timescale 1ns/1ns
`default_nettype none

module udp_frame_select #(
    parameter int port_count = 4
) (
    input  wire                           clk,
    input  wire                           rst,
    // source header channels
    input  wire                           s_hdr_valid [port_count],
    input  wire udp_mux_pkg::udp_hdr_t    s_hdr [port_count],
    output logic                          s_hdr_ready [port_count],
    // source payload channels
    input  wire                           s_pay_valid [port_count],
    input  wire udp_mux_pkg::udp_beat_t   s_pay [port_count],
    output logic                          s_pay_ready [port_count],
    // arbiter side
    input  wire                           grant_valid,
    input  wire [$clog2(port_count)-1:0]  grant_index,
    output logic [port_count-1:0]         request,
    output logic [port_count-1:0]         acknowledge,
    // output header
    output logic                          m_hdr_valid,
    input  wire                           m_hdr_ready,
    output udp_mux_pkg::udp_hdr_t         m_hdr,
    // to the skid stage
    output logic                          int_valid,
    output udp_mux_pkg::udp_beat_t        int_beat,
    input  wire                           int_ready
);

    import udp_mux_pkg::*;

    localparam int index_width = $clog2(port_count);

    frame_state_t frame_state;
    logic         hdr_take;
    logic         pay_fire;
    logic         sel_valid;
    udp_beat_t    sel_beat;

    // start only if the header slot is free or draining this cycle
    assign hdr_take = (frame_state == frame_idle) && grant_valid
                      && (!m_hdr_valid || m_hdr_ready);

    // granted port's payload
    assign sel_valid = s_pay_valid[grant_index];
    assign sel_beat  = s_pay[grant_index];

    // payload moves only once the header is captured
    assign int_valid = (frame_state == frame_busy) && sel_valid;
    assign int_beat  = sel_beat;
    assign pay_fire  = int_valid && int_ready;

    always_comb begin
        for (int n = 0; n < port_count; n++) begin
            s_hdr_ready[n] = hdr_take && (grant_index == index_width'(n));
            s_pay_ready[n] = (frame_state == frame_busy) && int_ready
                             && (grant_index == index_width'(n));
            // the granted port does not request again until released
            request[n]     = s_hdr_valid[n]
                             && !(grant_valid && (grant_index == index_width'(n)));
            acknowledge[n] = pay_fire && sel_beat.last
                             && (grant_index == index_width'(n));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_state <= frame_idle;
            m_hdr_valid <= 1'b0;
        end else begin
            if (hdr_take) begin
                frame_state <= frame_busy;
            end else if (pay_fire && sel_beat.last) begin
                frame_state <= frame_idle;
            end

            if (hdr_take) begin
                m_hdr_valid <= 1'b1;
            end else if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end
        end
    end

    // header register
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            m_hdr <= s_hdr[grant_index];
        end
    end

endmodule

`default_nettype wire

//--- logic/udp_payload_skid.sv
// registered payload output stage with a temporary slot and a registered input ready
`timescale 1ns/1ns
`default_nettype none

module udp_payload_skid (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         int_valid,
    input  wire udp_mux_pkg::udp_beat_t int_beat,
    output logic                        int_ready,
    output logic                        m_pay_valid,
    output udp_mux_pkg::udp_beat_t      m_pay,
    input  wire                         m_pay_ready
);

    import udp_mux_pkg::*;

    udp_beat_t temp_beat;
    logic      temp_valid;
    logic      int_ready_early;
    logic      out_valid_next;
    logic      temp_valid_next;
    logic      load_out_from_int;
    logic      load_temp_from_int;
    logic      load_out_from_temp;

    // ready next cycle unless the temp slot could fill up
    assign int_ready_early = m_pay_ready
                             || (!temp_valid && (!m_pay_valid || !int_valid));

    always_comb begin
        out_valid_next     = m_pay_valid;
        temp_valid_next    = temp_valid;
        load_out_from_int  = 1'b0;
        load_temp_from_int = 1'b0;
        load_out_from_temp = 1'b0;

        if (int_ready) begin
            if (m_pay_ready || !m_pay_valid) begin
                // output free, go straight there
                out_valid_next    = int_valid;
                load_out_from_int = 1'b1;
            end else begin
                // output stalled, park in temp
                temp_valid_next    = int_valid;
                load_temp_from_int = 1'b1;
            end
        end else if (m_pay_ready) begin
            // input closed, drain temp into output
            out_valid_next     = temp_valid;
            temp_valid_next    = 1'b0;
            load_out_from_temp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_pay_valid <= 1'b0;
            temp_valid  <= 1'b0;
            int_ready   <= 1'b0;
        end else begin
            m_pay_valid <= out_valid_next;
            temp_valid  <= temp_valid_next;
            int_ready   <= int_ready_early;
        end
    end

    // beat registers
    always_ff @(posedge clk) begin
        if (load_out_from_int) begin
            m_pay <= int_beat;
        end else if (load_out_from_temp) begin
            m_pay <= temp_beat;
        end

        if (load_temp_from_int) begin
            temp_beat <= int_beat;
        end
    end

endmodule

`default_nettype wire

//--- logic/udp_arb_mux.sv
// top level of the udp arbitrated mux: arbiter, frame selector and payload skid stage
`timescale 1ns/1ns
`default_nettype none

module udp_arb_mux #(
    parameter int port_count = 4
) (
    input  wire                         clk,
    input  wire                         rst,
    // source ports
    input  wire                         s_hdr_valid [port_count],
    output logic                        s_hdr_ready [port_count],
    input  wire udp_mux_pkg::udp_hdr_t  s_hdr [port_count],
    input  wire                         s_pay_valid [port_count],
    output logic                        s_pay_ready [port_count],
    input  wire udp_mux_pkg::udp_beat_t s_pay [port_count],
    // merged output
    output logic                        m_hdr_valid,
    input  wire                         m_hdr_ready,
    output udp_mux_pkg::udp_hdr_t       m_hdr,
    output logic                        m_pay_valid,
    input  wire                         m_pay_ready,
    output udp_mux_pkg::udp_beat_t      m_pay
);

    import udp_mux_pkg::*;

    logic [port_count-1:0]         request;
    logic [port_count-1:0]         acknowledge;
    logic                          grant_valid;
    logic [$clog2(port_count)-1:0] grant_index;

    // selector to skid stage
    logic      int_valid;
    udp_beat_t int_beat;
    logic      int_ready;

    rr_arbiter #(
        .port_count(port_count)
    ) i_rr_arbiter (
        .clk         (clk),
        .rst         (rst),
        .request     (request),
        .acknowledge (acknowledge),
        .grant_valid (grant_valid),
        .grant_index (grant_index)
    );

    udp_frame_select #(
        .port_count(port_count)
    ) i_udp_frame_select (
        .clk         (clk),
        .rst         (rst),
        .s_hdr_valid (s_hdr_valid),
        .s_hdr       (s_hdr),
        .s_hdr_ready (s_hdr_ready),
        .s_pay_valid (s_pay_valid),
        .s_pay       (s_pay),
        .s_pay_ready (s_pay_ready),
        .grant_valid (grant_valid),
        .grant_index (grant_index),
        .request     (request),
        .acknowledge (acknowledge),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr_ready (m_hdr_ready),
        .m_hdr       (m_hdr),
        .int_valid   (int_valid),
        .int_beat    (int_beat),
        .int_ready   (int_ready)
    );

    udp_payload_skid i_udp_payload_skid (
        .clk         (clk),
        .rst         (rst),
        .int_valid   (int_valid),
        .int_beat    (int_beat),
        .int_ready   (int_ready),
        .m_pay_valid (m_pay_valid),
        .m_pay       (m_pay),
        .m_pay_ready (m_pay_ready)
    );

endmodule

`default_nettype wire

//--- tests/udp_arb_mux_checker.sv
// output monitor: reset state, header and payload compare, frame order and stall stability
`timescale 1ns/1ns
`default_nettype none

module udp_arb_mux_checker (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         any_src_ready,
    input  wire                         m_hdr_valid,
    input  wire                         m_hdr_ready,
    input  wire udp_mux_pkg::udp_hdr_t  m_hdr,
    input  wire                         m_pay_valid,
    input  wire                         m_pay_ready,
    input  wire udp_mux_pkg::udp_beat_t m_pay,
    output int                          hdr_count,
    output int                          frame_count,
    output int                          error_count
);

    import udp_mux_pkg::*;

    // expected frames in output order
    udp_hdr_t   exp_hdr [$];
    int         exp_beats [$];
    logic [7:0] exp_first [$];

    int        beat_idx;
    logic      rst_q;
    logic      pay_valid_q;
    logic      pay_ready_q;
    udp_beat_t pay_q;

    initial begin
        hdr_count   = 0;
        frame_count = 0;
        error_count = 0;
        beat_idx    = 0;
    end

    task automatic expect_frame(input udp_hdr_t hdr, input int beats, input logic [7:0] first);
        exp_hdr.push_back(hdr);
        exp_beats.push_back(beats);
        exp_first.push_back(first);
    endtask

    task automatic check_header();
        udp_hdr_t want;
        if (hdr_count >= exp_hdr.size()) begin
            $display("header from port %0d arrived with no frame left to expect",
                     m_hdr.source_ip[7:0]);
            error_count++;
        end else begin
            want = exp_hdr[hdr_count];
            // low byte of source_ip names the source port
            if (m_hdr.source_ip[7:0] !== want.source_ip[7:0]) begin
                $display("ERROR m_hdr.source_ip port byte expected %h got %h",
                         want.source_ip[7:0], m_hdr.source_ip[7:0]);
                error_count++;
            end else if (m_hdr !== want) begin
                $display("ERROR m_hdr expected %h got %h", want, m_hdr);
                error_count++;
            end
            hdr_count++;
        end
    endtask

    task automatic check_beat();
        udp_beat_t  want;
        int         beats;
        logic [7:0] first;
        if (frame_count >= exp_beats.size()) begin
            $display("payload beat with data %h arrived after all frames ended", m_pay.data);
            error_count++;
        end else begin
            beats = exp_beats[frame_count];
            first = exp_first[frame_count];
            if (beat_idx == 0 && hdr_count < frame_count) begin
                $display("payload of frame %0d started before the header of frame %0d was sent",
                         frame_count, frame_count - 1);
                error_count++;
            end
            want.data = first + beat_idx[7:0];
            want.last = (beat_idx == beats - 1);
            want.user = want.last && first[0];
            if (m_pay !== want) begin
                $display("ERROR m_pay frame %0d beat %0d expected %h got %h",
                         frame_count, beat_idx, want, m_pay);
                error_count++;
            end
            beat_idx++;
            if (beat_idx == beats) begin
                beat_idx = 0;
                frame_count++;
            end
        end
    endtask

    always @(posedge clk) begin
        rst_q       <= rst;
        pay_valid_q <= m_pay_valid;
        pay_ready_q <= m_pay_ready;
        pay_q       <= m_pay;
        if (rst_q) begin
            if (m_hdr_valid !== 1'b0 || m_pay_valid !== 1'b0 || any_src_ready !== 1'b0) begin
                $display("reset state wrong: an output valid or a source ready is not low");
                error_count++;
            end
        end else begin
            // a stalled beat must hold
            if (pay_valid_q === 1'b1 && pay_ready_q === 1'b0) begin
                if (m_pay_valid !== 1'b1 || m_pay !== pay_q) begin
                    $display("ERROR m_pay changed while stalled, expected %h got %h",
                             pay_q, m_pay);
                    error_count++;
                end
            end
            if (m_hdr_valid && m_hdr_ready) begin
                check_header();
            end
            if (m_pay_valid && m_pay_ready) begin
                check_beat();
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/udp_arb_mux_tb.sv
// testbench top: clock, reset, test file reader, source drivers, sink stalls, watchdog, summary
`timescale 1ns/1ns
`default_nettype none

module udp_arb_mux_tb;

    import udp_mux_pkg::*;

    localparam int port_count = 4;
    localparam int max_frames = 64;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      s_hdr_valid [port_count];
    logic      s_hdr_ready [port_count];
    udp_hdr_t  s_hdr [port_count];
    logic      s_pay_valid [port_count];
    logic      s_pay_ready [port_count];
    udp_beat_t s_pay [port_count];
    logic      m_hdr_valid;
    logic      m_hdr_ready = 1'b0;
    udp_hdr_t  m_hdr;
    logic      m_pay_valid;
    logic      m_pay_ready = 1'b0;
    udp_beat_t m_pay;
    logic      any_src_ready;

    int hdr_count;
    int frame_count;
    int error_count;

    // one entry per frame line of the test file
    int         f_test [max_frames];
    logic       f_stall [max_frames];
    int         f_port [max_frames];
    udp_hdr_t   f_hdr [max_frames];
    int         f_beats [max_frames];
    logic [7:0] f_first [max_frames];
    int         frame_total = 0;
    int         beat_total = 0;
    int         last_test = 0;
    logic       load_ok = 1'b0;
    logic       file_loaded = 1'b0;

    logic        stall_enable = 1'b0;
    logic [31:0] lcg_state = 32'hc3c7_79f5;
    int          tests_passed = 0;
    int          tests_failed = 0;

    udp_arb_mux #(
        .port_count(port_count)
    ) i_udp_arb_mux (
        .clk         (clk),
        .rst         (rst),
        .s_hdr_valid (s_hdr_valid),
        .s_hdr_ready (s_hdr_ready),
        .s_hdr       (s_hdr),
        .s_pay_valid (s_pay_valid),
        .s_pay_ready (s_pay_ready),
        .s_pay       (s_pay),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr_ready (m_hdr_ready),
        .m_hdr       (m_hdr),
        .m_pay_valid (m_pay_valid),
        .m_pay_ready (m_pay_ready),
        .m_pay       (m_pay)
    );

    udp_arb_mux_checker i_checker (
        .clk           (clk),
        .rst           (rst),
        .any_src_ready (any_src_ready),
        .m_hdr_valid   (m_hdr_valid),
        .m_hdr_ready   (m_hdr_ready),
        .m_hdr         (m_hdr),
        .m_pay_valid   (m_pay_valid),
        .m_pay_ready   (m_pay_ready),
        .m_pay         (m_pay),
        .hdr_count     (hdr_count),
        .frame_count   (frame_count),
        .error_count   (error_count)
    );

    always #2 clk = ~clk;

    always_comb begin
        any_src_ready = 1'b0;
        for (int n = 0; n < port_count; n++) begin
            any_src_ready = any_src_ready | s_hdr_ready[n] | s_pay_ready[n];
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // random sink stalls only in tests that ask for them
    always @(posedge clk) begin
        #1;
        if (stall_enable) begin
            lcg_state   = lcg_next(lcg_state);
            m_pay_ready = lcg_state[29] | lcg_state[22];
            m_hdr_ready = lcg_state[31];
        end else begin
            m_pay_ready = 1'b1;
            m_hdr_ready = 1'b1;
        end
    end

    task automatic load_tests();
        int         fd;
        int         n;
        string      line;
        int         t;
        int         stall;
        int         p;
        int         beats;
        logic [47:0] dmac;
        logic [47:0] smac;
        logic [15:0] len;
        logic [31:0] sip;
        logic [31:0] dip;
        logic [7:0]  first;
        udp_hdr_t    hdr;
        fd = $fopen("tests/udp_arb_mux_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file tests/udp_arb_mux_tests.txt");
        end else begin
            load_ok = 1'b1;
            while (!$feof(fd) && frame_total < max_frames) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %h %h %h %h %h %d %h",
                                t, stall, p, dmac, smac, len, sip, dip, beats, first);
                    if (n == 10) begin
                        hdr.dest_mac  = dmac;
                        hdr.src_mac   = smac;
                        hdr.length    = len;
                        hdr.source_ip = sip;
                        hdr.dest_ip   = dip;
                        f_test[frame_total]  = t;
                        f_stall[frame_total] = (stall != 0);
                        f_port[frame_total]  = p;
                        f_hdr[frame_total]   = hdr;
                        f_beats[frame_total] = beats;
                        f_first[frame_total] = first;
                        frame_total++;
                        beat_total += beats;
                        if (t > last_test) begin
                            last_test = t;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // called 1 ns after a rising edge
    task automatic send_header(input int p, input udp_hdr_t hdr);
        s_hdr[p]       = hdr;
        s_hdr_valid[p] = 1'b1;
        @(posedge clk);
        while (!s_hdr_ready[p]) begin
            @(posedge clk);
        end
        #1;
        s_hdr_valid[p] = 1'b0;
    endtask

    task automatic send_payload(input int p, input int beats, input logic [7:0] first);
        udp_beat_t  beat;
        logic [7:0] data_byte;
        data_byte = first;
        for (int k = 0; k < beats; k++) begin
            beat.data      = data_byte;
            beat.last      = (k == beats - 1);
            // user flag rides on the last beat of odd-start frames
            beat.user      = beat.last && first[0];
            s_pay[p]       = beat;
            s_pay_valid[p] = 1'b1;
            @(posedge clk);
            while (!s_pay_ready[p]) begin
                @(posedge clk);
            end
            #1;
            data_byte++;
        end
        s_pay_valid[p] = 1'b0;
    endtask

    // frames of one test on one port in file order
    task automatic drive_port(input int p, input int t);
        for (int i = 0; i < frame_total; i++) begin
            if (f_test[i] == t && f_port[i] == p) begin
                send_header(p, f_hdr[i]);
                send_payload(p, f_beats[i], f_first[i]);
            end
        end
    endtask

    task automatic record_result(input int t, input int n, input bit ok);
        $display("test %0d: %0d frames, %s", t, n, ok ? "passed" : "failed");
        if (ok) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
    endtask

    initial begin : watchdog
        int limit;
        wait (file_loaded);
        limit = 40 * beat_total + 200;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main_flow
        int errors_before;
        int sent_frames;
        int n;
        for (int p = 0; p < port_count; p++) begin
            s_hdr_valid[p] = 1'b0;
            s_hdr[p]       = '0;
            s_pay_valid[p] = 1'b0;
            s_pay[p]       = '0;
        end
        load_tests();
        file_loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        // the monitor checks every reset cycle and the first one after
        $display("reset state: %s", (error_count == 0) ? "passed" : "failed");
        if (error_count == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end

        sent_frames = 0;
        for (int t = 1; t <= last_test; t++) begin
            n = 0;
            @(posedge clk);
            for (int i = 0; i < frame_total; i++) begin
                if (f_test[i] == t) begin
                    n++;
                    stall_enable = f_stall[i];
                    i_checker.expect_frame(f_hdr[i], f_beats[i], f_first[i]);
                end
            end
            if (n > 0) begin
                errors_before = error_count;
                #1;
                fork
                    drive_port(0, t);
                    drive_port(1, t);
                    drive_port(2, t);
                    drive_port(3, t);
                join
                sent_frames += n;
                // drained when every header and payload has left the DUT
                wait (hdr_count == sent_frames && frame_count == sent_frames);
                #1;
                record_result(t, n, error_count == errors_before);
            end
        end

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (!load_ok || frame_total == 0 || tests_failed != 0 || error_count != 0) begin
            $display("SOME TESTS FAILED");
        end else begin
            $display("ALL TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/udp_arb_mux_tests.txt
# test stall port dest_mac src_mac length source_ip dest_ip beats first_byte
# test, stall, port and beats in decimal, the rest in hex; source_ip low byte is the port
1 0 0 02aabbcc0001 02112233440a 000c 0a000100 c0a80001 4 10
2 0 3 02aabbcc0002 02112233440b 000b 0a000203 c0a80002 3 21
3 0 0 02aabbcc0003 02112233440c 000d 0a000300 c0a80003 5 30
3 0 1 02aabbcc0004 02112233440d 000a 0a000401 c0a80004 2 41
3 0 2 02aabbcc0005 02112233440e 000b 0a000502 c0a80005 3 50
3 0 3 02aabbcc0006 02112233440f 000e 0a000603 c0a80006 6 63
3 0 0 02aabbcc0007 021122334410 000c 0a000700 c0a80007 4 70
3 0 1 02aabbcc0008 021122334411 0009 0a000801 c0a80008 1 85
3 0 2 02aabbcc0009 021122334412 000a 0a000902 c0a80009 2 90
3 0 3 02aabbcc000a 021122334413 000b 0a000a03 c0a8000a 3 a1
4 1 0 02aabbcc000b 021122334414 000e 0a000b00 c0a8000b 6 fd
4 1 1 02aabbcc000c 021122334415 000b 0a000c01 c0a8000c 3 11
4 1 2 02aabbcc000d 021122334416 000c 0a000d02 c0a8000d 4 22
4 1 3 02aabbcc000e 021122334417 000a 0a000e03 c0a8000e 2 33
4 1 0 02aabbcc000f 021122334418 000d 0a000f00 c0a8000f 5 45
4 1 2 02aabbcc0010 021122334419 000b 0a001002 c0a80010 3 58
5 1 1 02aabbcc0011 02112233441a 0009 0a001101 c0a80011 1 07

//--- build.f
logic/udp_mux_pkg.sv
logic/rr_arbiter.sv
logic/udp_frame_select.sv
logic/udp_payload_skid.sv
logic/udp_arb_mux.sv
tests/udp_arb_mux_checker.sv
tests/udp_arb_mux_tb.sv
